// File: common/pads_pkg.sv
// Pad side constants
`default_nettype none

package pads_pkg;

	// Flops per pin synchronizer, two as in the PHI1/PHI2 latch pair
	localparam int DEFAULT_SYNC_STAGES = 2;

	// Pins that go through the synchronizer chain
	localparam int NUM_PINS = 5;

	// Bit positions inside the synchronizer word
	localparam int PIN_NMI = 0;
	localparam int PIN_IRQ = 1;
	localparam int PIN_RES = 2;
	localparam int PIN_SO = 3;
	localparam int PIN_RDY = 4;

	// Inactive level per bit after reset
	// Interrupts and SO idle low once inverted, RDY idles as ready
	localparam logic [NUM_PINS-1:0] PIN_RST_LEVEL = 5'b1_0000;

endpackage : pads_pkg

`default_nettype wire

// File: common/intr_pkg.sv
// Interrupt kinds and vectors
`default_nettype none

package intr_pkg;

	// Kind of the interrupt being taken
	// NONE while idle, then ranked upward by priority
	typedef enum logic [1:0] {
		KIND_NONE  = 2'd0,
		KIND_IRQ   = 2'd1,
		KIND_NMI   = 2'd2,
		KIND_RESET = 2'd3
	} int_kind_t;

	// Vector addresses in the top page
	// Low byte of each pointer, high byte follows at +1
	localparam logic [15:0] VEC_NMI = 16'hfffa;
	localparam logic [15:0] VEC_RESET = 16'hfffc;
	// Shared with BRK in the full core
	localparam logic [15:0] VEC_IRQ = 16'hfffe;

	// Vector for a given kind, zero when nothing is taken
	function automatic logic [15:0] kind_vector(input int_kind_t kind);
		case (kind)
			KIND_RESET: return VEC_RESET;
			KIND_NMI: return VEC_NMI;
			KIND_IRQ: return VEC_IRQ;
			default: return 16'h0000;
		endcase
	endfunction

endpackage : intr_pkg

`default_nettype wire

// File: verilog/pads_logic.sv
// Pad logic
`timescale 1ns/1ns
`default_nettype none

module pads_logic #(
	parameter int SYNC_STAGES = pads_pkg::DEFAULT_SYNC_STAGES
) (
	input  logic phi0,
	input  logic rst,
	// Pins, interrupts and SO active low
	input  logic n_nmi,
	input  logic n_irq,
	input  logic n_res,
	input  logic n_so,
	input  logic rdy,
	// Strobes from the core
	input  logic t1,
	input  logic wr,
	// Synchronized levels, all active high
	output logic nmi_p,
	output logic irq_p,
	output logic res_p,
	output logic so_p,
	output logic rdy_p,
	output logic sync,
	output logic rnw
);

	import pads_pkg::*;

	// Pins gathered into one word, inverted to active high
	logic [NUM_PINS-1:0] pins_in;
	// Synchronizer chain, stage 0 nearest the pads
	logic [SYNC_STAGES-1:0][NUM_PINS-1:0] chain;

	assign pins_in[PIN_NMI] = ~n_nmi;
	assign pins_in[PIN_IRQ] = ~n_irq;
	assign pins_in[PIN_RES] = ~n_res;
	assign pins_in[PIN_SO] = ~n_so;
	assign pins_in[PIN_RDY] = rdy;

	// Shift every pin one stage per phi0 edge
	// Needs at least two stages
	always_ff @(posedge phi0) begin
		if (rst) begin
			chain <= {SYNC_STAGES{PIN_RST_LEVEL}};
		end else begin
			chain <= {chain[SYNC_STAGES-2:0], pins_in};
		end
	end

	// Last stage feeds the core
	assign nmi_p = chain[SYNC_STAGES-1][PIN_NMI];
	assign irq_p = chain[SYNC_STAGES-1][PIN_IRQ];
	assign res_p = chain[SYNC_STAGES-1][PIN_RES];
	assign so_p = chain[SYNC_STAGES-1][PIN_SO];
	assign rdy_p = chain[SYNC_STAGES-1][PIN_RDY];

	// SYNC marks the opcode fetch cycle, same cycle as t1
	assign sync = t1;

	// Read unless the core writes, one cycle behind wr
	always_ff @(posedge phi0) begin
		if (rst) begin
			rnw <= 1'b1;
		end else begin
			rnw <= ~wr;
		end
	end

	// Bus comes out of reset reading
	a_rnw_after_rst: assert property (@(posedge phi0) rst |=> rnw);

endmodule : pads_logic

`default_nettype wire

// File: interrupt/nmi_irq_detect.sv
// NMI, IRQ and reset detection
`timescale 1ns/1ns
`default_nettype none

module nmi_irq_detect (
	input  logic phi0,
	input  logic rst,
	// Synchronized pin levels
	input  logic nmi_p,
	input  logic irq_p,
	input  logic res_p,
	// Interrupt disable flag from the core
	input  logic i_flag,
	// Acknowledges from the vector selector
	input  logic nmi_ack,
	input  logic irq_ack,
	input  logic res_ack,
	output logic nmi_pend,
	output logic irq_pend,
	output logic res_pend
);

	// Previous NMI level for edge detection
	logic nmi_prev;
	logic nmi_edge;

	assign nmi_edge = nmi_p & ~nmi_prev;

	always_ff @(posedge phi0) begin
		if (rst) begin
			nmi_prev <= 1'b0;
		end else begin
			nmi_prev <= nmi_p;
		end
	end

	// NMI latch
	// A new edge wins over an ack in the same cycle
	always_ff @(posedge phi0) begin
		if (rst) begin
			nmi_pend <= 1'b0;
		end else if (nmi_edge) begin
			nmi_pend <= 1'b1;
		end else if (nmi_ack) begin
			nmi_pend <= 1'b0;
		end
	end

	// IRQ is a level, masked by I and sampled every cycle
	// Source must hold the line until serviced
	always_ff @(posedge phi0) begin
		if (rst) begin
			irq_pend <= 1'b0;
		end else begin
			irq_pend <= irq_p & ~i_flag;
		end
	end

	// Reset latch
	// Held while the pin is asserted, ack only counts once it is released
	always_ff @(posedge phi0) begin
		if (rst) begin
			res_pend <= 1'b0;
		end else if (res_p) begin
			res_pend <= 1'b1;
		end else if (res_ack) begin
			res_pend <= 1'b0;
		end
	end

	// Selector only acks an NMI that is latched here
	a_nmi_ack_pend: assert property (@(posedge phi0) disable iff (rst)
		nmi_ack |-> nmi_pend);

	// IRQ ack follows a cycle with the level pending
	a_irq_ack_pend: assert property (@(posedge phi0) disable iff (rst)
		irq_ack |-> $past(irq_pend));

endmodule : nmi_irq_detect

`default_nettype wire

// File: verilog/rdy_so_ctrl.sv
// RDY stall and SO pulse
`timescale 1ns/1ns
`default_nettype none

module rdy_so_ctrl (
	input  logic phi0,
	input  logic rst,
	// Synchronized ready level
	input  logic rdy_p,
	// Synchronized set overflow level
	input  logic so_p,
	// Registered bus direction
	input  logic rnw,
	output logic stall,
	output logic so_set
);

	// Previous SO level
	logic so_prev;

	// RDY only halts read cycles on the NMOS part
	// Writes complete regardless of the pin
	assign stall = ~rdy_p & rnw;

	always_ff @(posedge phi0) begin
		if (rst) begin
			so_prev <= 1'b0;
		end else begin
			so_prev <= so_p;
		end
	end

	// One cycle pulse on the rising edge of so_p
	// Holding the pin low gives nothing further
	always_ff @(posedge phi0) begin
		if (rst) begin
			so_set <= 1'b0;
		end else begin
			so_set <= so_p & ~so_prev;
		end
	end

	// Write cycles are never held
	a_no_write_stall: assert property (@(posedge phi0) disable iff (rst)
		!rnw |-> !stall);

endmodule : rdy_so_ctrl

`default_nettype wire

// File: interrupt/int_vector_sel.sv
// Interrupt vector selection
`timescale 1ns/1ns
`default_nettype none

module int_vector_sel (
	input  logic phi0,
	input  logic rst,
	// Instruction boundary from the core
	input  logic t1,
	input  logic stall,
	// Pending sources
	input  logic nmi_pend,
	input  logic irq_pend,
	input  logic res_pend,
	output logic int_take,
	output intr_pkg::int_kind_t int_kind,
	output logic [15:0] int_vec,
	// Clears back to the detector
	output logic nmi_ack,
	output logic irq_ack,
	output logic res_ack
);

	import intr_pkg::*;

	// Boundary accepted this cycle
	logic accept;
	// Highest priority source right now
	int_kind_t pick;

	// No take while stalled, and none right after a take
	// The acked flag is still visible for one more cycle
	assign accept = t1 & ~stall & ~int_take;

	// Reset first, then NMI, then IRQ
	always_comb begin
		if (res_pend) begin
			pick = KIND_RESET;
		end else if (nmi_pend) begin
			pick = KIND_NMI;
		end else if (irq_pend) begin
			pick = KIND_IRQ;
		end else begin
			pick = KIND_NONE;
		end
	end

	// Outputs registered, one cycle after the boundary
	always_ff @(posedge phi0) begin
		if (rst) begin
			int_take <= 1'b0;
			int_kind <= KIND_NONE;
			int_vec <= 16'h0000;
			nmi_ack <= 1'b0;
			irq_ack <= 1'b0;
			res_ack <= 1'b0;
		end else if (accept && pick != KIND_NONE) begin
			int_take <= 1'b1;
			int_kind <= pick;
			int_vec <= kind_vector(pick);
			nmi_ack <= (pick == KIND_NMI);
			irq_ack <= (pick == KIND_IRQ);
			res_ack <= (pick == KIND_RESET);
		end else begin
			// Idle, kind and vector back to zero
			int_take <= 1'b0;
			int_kind <= KIND_NONE;
			int_vec <= 16'h0000;
			nmi_ack <= 1'b0;
			irq_ack <= 1'b0;
			res_ack <= 1'b0;
		end
	end

	// Only one source serviced per take
	a_one_ack: assert property (@(posedge phi0) disable iff (rst)
		$onehot0({nmi_ack, irq_ack, res_ack}));

endmodule : int_vector_sel

`default_nettype wire

// File: verilog/int_front_top.sv
// Interrupt front end top
`timescale 1ns/1ns
`default_nettype none

module int_front_top #(
	parameter int SYNC_STAGES = pads_pkg::DEFAULT_SYNC_STAGES
) (
	input  logic phi0,
	input  logic rst,
	// External pins
	input  logic n_nmi,
	input  logic n_irq,
	input  logic n_res,
	input  logic n_so,
	input  logic rdy,
	// Core side
	input  logic t1,
	input  logic wr,
	input  logic i_flag,
	output logic sync,
	output logic rnw,
	output logic stall,
	output logic so_set,
	output logic int_take,
	output intr_pkg::int_kind_t int_kind,
	output logic [15:0] int_vec
);

	// Synchronized pin levels
	logic nmi_p;
	logic irq_p;
	logic res_p;
	logic so_p;
	logic rdy_p;
	// Pending flags and their clears
	logic nmi_pend;
	logic irq_pend;
	logic res_pend;
	logic nmi_ack;
	logic irq_ack;
	logic res_ack;

	pads_logic #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_pads (
		.phi0(phi0), .rst(rst),
		.n_nmi(n_nmi), .n_irq(n_irq), .n_res(n_res), .n_so(n_so), .rdy(rdy),
		.t1(t1), .wr(wr),
		.nmi_p(nmi_p), .irq_p(irq_p), .res_p(res_p), .so_p(so_p), .rdy_p(rdy_p),
		.sync(sync), .rnw(rnw)
	);

	nmi_irq_detect u_detect (
		.phi0(phi0), .rst(rst),
		.nmi_p(nmi_p), .irq_p(irq_p), .res_p(res_p), .i_flag(i_flag),
		.nmi_ack(nmi_ack), .irq_ack(irq_ack), .res_ack(res_ack),
		.nmi_pend(nmi_pend), .irq_pend(irq_pend), .res_pend(res_pend)
	);

	rdy_so_ctrl u_rdy_so (
		.phi0(phi0), .rst(rst),
		.rdy_p(rdy_p), .so_p(so_p), .rnw(rnw),
		.stall(stall), .so_set(so_set)
	);

	// Stall also gates the boundary here
	int_vector_sel u_sel (
		.phi0(phi0), .rst(rst),
		.t1(t1), .stall(stall),
		.nmi_pend(nmi_pend), .irq_pend(irq_pend), .res_pend(res_pend),
		.int_take(int_take), .int_kind(int_kind), .int_vec(int_vec),
		.nmi_ack(nmi_ack), .irq_ack(irq_ack), .res_ack(res_ack)
	);

endmodule : int_front_top

`default_nettype wire

// File: sim/tb_int_front.sv
// Interrupt front end testbench
`timescale 1ns/1ns
`default_nettype none

module tb_int_front;

	import intr_pkg::*;

	// Cycle budget of each test
	localparam int LEN_AFTER_RST = 20;
	localparam int LEN_RESET = 20;
	localparam int LEN_NMI = 40;
	localparam int LEN_IRQ = 40;
	localparam int LEN_RDY = 35;
	localparam int LEN_SO = 70;
	// Run limit is twice the summed budgets
	localparam int TIMEOUT_CYCLES = 2 * (LEN_AFTER_RST + LEN_RESET + LEN_NMI + LEN_IRQ
		+ LEN_RDY + LEN_SO);

	logic phi0;
	logic rst;
	logic n_nmi;
	logic n_irq;
	logic n_res;
	logic n_so;
	logic rdy;
	logic t1;
	logic wr;
	logic i_flag;
	logic sync;
	logic rnw;
	logic stall;
	logic so_set;
	logic int_take;
	int_kind_t int_kind;
	logic [15:0] int_vec;

	int checks;
	int errors;
	int cycles;
	logic [31:0] seed;

	int_front_top UUT (
		.phi0(phi0), .rst(rst),
		.n_nmi(n_nmi), .n_irq(n_irq), .n_res(n_res), .n_so(n_so), .rdy(rdy),
		.t1(t1), .wr(wr), .i_flag(i_flag),
		.sync(sync), .rnw(rnw), .stall(stall), .so_set(so_set),
		.int_take(int_take), .int_kind(int_kind), .int_vec(int_vec)
	);

	// 4 ns clock
	always #2 phi0 = ~phi0;

	// Run limit
	always @(posedge phi0) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests still running after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Advance to 1 ns past the next rising edge
	task automatic tick();
		@(posedge phi0);
		#1;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_kind(input string name, input int_kind_t got, input int_kind_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_vec(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Count takes over a window of n cycles
	// Idle cycles show no kind and no vector
	task automatic watch_takes(input int n, input int_kind_t kind, input logic [15:0] vec,
		output int cnt);
		int i;
		cnt = 0;
		for (i = 0; i < n; i++) begin
			tick();
			if (int_take) begin
				cnt++;
				check_kind("int_kind", int_kind, kind);
				check_vec("int_vec", int_vec, vec);
			end else begin
				check_kind("int_kind", int_kind, KIND_NONE);
				check_vec("int_vec", int_vec, 16'h0000);
			end
		end
	endtask

	// Wait up to limit cycles for a take
	task automatic wait_take(input int limit, input int_kind_t kind, input logic [15:0] vec);
		int n;
		n = 0;
		while (!int_take && n < limit) begin
			tick();
			n++;
		end
		if (int_take) begin
			check_kind("int_kind", int_kind, kind);
			check_vec("int_vec", int_vec, vec);
		end else begin
			errors++;
			$display("No interrupt taken within %0d cycles at %0t", limit, $time);
		end
	endtask

	task automatic reset_state_and_bus();
		int i;
		logic [31:0] r;
		logic prev_wr;
		prev_wr = 1'b0;
		check_bit("rnw", rnw, 1'b1);
		check_bit("int_take", int_take, 1'b0);
		check_bit("so_set", so_set, 1'b0);
		check_bit("stall", stall, 1'b0);
		// rnw is the inverse of wr one cycle later
		// Old value holds until the edge
		for (i = 0; i < 8; i++) begin
			r = next_rand();
			wr = r[9];
			#1;
			check_bit("rnw", rnw, ~prev_wr);
			tick();
			check_bit("rnw", rnw, ~r[9]);
			prev_wr = r[9];
		end
		wr = 1'b0;
		tick();
		// SYNC is t1 in the same cycle
		t1 = 1'b1;
		#1;
		check_bit("sync", sync, 1'b1);
		tick();
		t1 = 1'b0;
		#1;
		check_bit("sync", sync, 1'b0);
		tick();
	endtask

	task automatic reset_interrupt();
		int cnt;
		n_res = 1'b0;
		repeat (3) tick();
		n_res = 1'b1;
		// Let res_p fall so the ack can clear the latch
		repeat (4) tick();
		t1 = 1'b1;
		tick();
		check_bit("int_take", int_take, 1'b1);
		check_kind("int_kind", int_kind, KIND_RESET);
		check_vec("int_vec", int_vec, 16'hfffc);
		watch_takes(6, KIND_RESET, 16'hfffc, cnt);
		check_count("reset retakes", cnt, 0);
		t1 = 1'b0;
		tick();
	endtask

	task automatic nmi_edge_trigger();
		int cnt;
		t1 = 1'b1;
		// One take for a level held across many boundaries
		n_nmi = 1'b0;
		watch_takes(12, KIND_NMI, 16'hfffa, cnt);
		check_count("nmi takes", cnt, 1);
		n_nmi = 1'b1;
		watch_takes(6, KIND_NMI, 16'hfffa, cnt);
		check_count("nmi takes on release", cnt, 0);
		// Second falling edge
		n_nmi = 1'b0;
		watch_takes(12, KIND_NMI, 16'hfffa, cnt);
		check_count("nmi takes", cnt, 1);
		n_nmi = 1'b1;
		t1 = 1'b0;
		repeat (4) tick();
	endtask

	task automatic irq_mask_and_rank();
		int cnt;
		i_flag = 1'b1;
		n_irq = 1'b0;
		t1 = 1'b1;
		watch_takes(10, KIND_IRQ, 16'hfffe, cnt);
		check_count("masked irq takes", cnt, 0);
		i_flag = 1'b0;
		wait_take(6, KIND_IRQ, 16'hfffe);
		// Core sets I on entry while the level stays low
		i_flag = 1'b1;
		watch_takes(6, KIND_IRQ, 16'hfffe, cnt);
		check_count("irq takes after I set", cnt, 0);
		n_irq = 1'b1;
		t1 = 1'b0;
		repeat (3) tick();
		// NMI ranks above a pending IRQ
		i_flag = 1'b0;
		n_irq = 1'b0;
		n_nmi = 1'b0;
		repeat (4) tick();
		t1 = 1'b1;
		tick();
		check_bit("int_take", int_take, 1'b1);
		check_kind("int_kind", int_kind, KIND_NMI);
		check_vec("int_vec", int_vec, 16'hfffa);
		i_flag = 1'b1;
		t1 = 1'b0;
		n_nmi = 1'b1;
		n_irq = 1'b1;
		repeat (4) tick();
	endtask

	task automatic rdy_read_stall();
		int cnt;
		rdy = 1'b0;
		wr = 1'b0;
		n_nmi = 1'b0;
		repeat (4) tick();
		check_bit("stall", stall, 1'b1);
		// Boundary held off while stalled
		t1 = 1'b1;
		watch_takes(6, KIND_NMI, 16'hfffa, cnt);
		check_count("takes while stalled", cnt, 0);
		rdy = 1'b1;
		wait_take(6, KIND_NMI, 16'hfffa);
		t1 = 1'b0;
		n_nmi = 1'b1;
		repeat (3) tick();
		// Writes pass with rdy low
		rdy = 1'b0;
		wr = 1'b1;
		repeat (4) tick();
		check_bit("stall", stall, 1'b0);
		wr = 1'b0;
		tick();
		check_bit("stall", stall, 1'b1);
		rdy = 1'b1;
		repeat (3) tick();
		check_bit("stall", stall, 1'b0);
	endtask

	task automatic so_edge_pulse();
		int i;
		int low;
		int high;
		int cnt;
		logic [31:0] r;
		// Low and high spans from the LCG
		for (i = 0; i < 4; i++) begin
			r = next_rand();
			low = 1 + int'(r[1:0]);
			high = 4 + int'(r[5:4]);
			cnt = 0;
			n_so = 1'b0;
			repeat (low) begin
				tick();
				cnt += int'(so_set);
			end
			n_so = 1'b1;
			repeat (high) begin
				tick();
				cnt += int'(so_set);
			end
			check_count("so_set pulses", cnt, 1);
		end
		// Only the first edge counts while held low
		n_so = 1'b0;
		cnt = 0;
		repeat (20) begin
			tick();
			cnt += int'(so_set);
		end
		check_count("so_set pulses held low", cnt, 1);
		n_so = 1'b1;
		tick();
	endtask

	initial begin
		phi0 = 1'b0;
		rst = 1'b1;
		n_nmi = 1'b1;
		n_irq = 1'b1;
		n_res = 1'b1;
		n_so = 1'b1;
		rdy = 1'b1;
		t1 = 1'b0;
		wr = 1'b0;
		i_flag = 1'b1;
		checks = 0;
		errors = 0;
		cycles = 0;
		seed = 32'hdf60;
		repeat (2) @(posedge phi0);
		#1;
		rst = 1'b0;
		reset_state_and_bus();
		reset_interrupt();
		nmi_edge_trigger();
		irq_mask_and_rank();
		rdy_read_stall();
		so_edge_pulse();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule : tb_int_front

`default_nettype wire

// File: flist.f
common/pads_pkg.sv
common/intr_pkg.sv
verilog/pads_logic.sv
interrupt/nmi_irq_detect.sv
verilog/rdy_so_ctrl.sv
interrupt/int_vector_sel.sv
verilog/int_front_top.sv
sim/tb_int_front.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt front end testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_int_front \
	-f flist.f > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_int_front > sim.log 2>&1 || { echo "Simulation did not complete"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"
